//--- list.f
src/mem_if_pkg.sv
src/traffic_pkg.sv
src/addr_sweep.sv
src/test_sequencer.sv
src/pattern_control.sv
src/byte_lane_checker.sv
src/pnf_collector.sv
src/ddr2_traffic_gen.sv
tb/traffic_checker.sv
tb/tb_ddr2_traffic_gen.sv

//--- run.sh
#!/bin/sh
# Build and run the traffic generator testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f \
  --top-module tb_ddr2_traffic_gen -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0

//--- src/addr_sweep.sv
// Nested column, row and bank counter for the address sweep.
// Column steps by twice burst_len and wraps once it reaches max_col.
// Limits must fit the local port address widths.
module addr_sweep
  import mem_if_pkg::*;
#(
  parameter int max_row   = 3,
  parameter int max_col   = 16,
  parameter int max_bank  = 3,
  parameter int burst_len = 2
) (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  addr_restart,
  input  logic  addr_step,
  output row_t  row,
  output col_t  col,
  output bank_t bank,
  output logic  at_last
);

  localparam int col_step = 2 * burst_len;

  logic col_wrap;
  logic row_wrap;
  logic bank_wrap;

  assign col_wrap  = (col >= col_t'(max_col));
  assign row_wrap  = (row == row_t'(max_row));
  assign bank_wrap = (bank == bank_t'(max_bank));
  assign at_last   = col_wrap & row_wrap & bank_wrap;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      row  <= '0;
      col  <= '0;
      bank <= '0;
    end
    else if (addr_restart)
    begin
      row  <= '0;
      col  <= '0;
      bank <= '0;
    end
    else if (addr_step)
    begin
      if (!col_wrap)
        col <= col + col_t'(col_step);
      else
      begin
        col <= '0;
        // carry into row, then bank
        if (!row_wrap)
          row <= row + row_t'(1);
        else
        begin
          row  <= '0;
          bank <= bank_wrap ? '0 : bank + bank_t'(1);
        end
      end
    end
  end

endmodule

//--- src/byte_lane_checker.sv
// One byte lane: LFSR pattern source and read data compare.
// Bytes with be_bit low are expected to read back as zero.
// lane_ok is valid one cycle after each read beat.
module byte_lane_checker
  import traffic_pkg::*;
#(
  parameter lane_t seed = 8'd1
) (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  lane_restart,
  input  logic  lane_step,
  input  logic  zero_data,
  input  logic  be_bit,
  input  lane_t rdata_byte,
  input  logic  rdata_valid,
  output lane_t wbyte,
  output logic  lane_ok,
  output logic  lane_ok_valid
);

  lane_t pattern;
  lane_t expected;

  assign wbyte    = zero_data ? '0 : pattern;
  assign expected = pattern & {8{be_bit}};

  // shift left, tap parity into bit 0
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      pattern <= seed;
    else if (lane_restart)
      pattern <= seed;
    else if (lane_step)
      pattern <= {pattern[6:0], ^(pattern & lfsr_taps)};
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lane_ok       <= 1'b1;
      lane_ok_valid <= 1'b0;
    end
    else
    begin
      lane_ok_valid <= rdata_valid;
      if (rdata_valid)
        lane_ok <= (rdata_byte == expected);
    end
  end

endmodule

//--- src/ddr2_traffic_gen.sv
// Traffic generator for a DDR2 controller local port.
// Writes an LFSR pattern over an address sweep, reads it back and checks
// it per byte lane. Runs the sequential and byte-enable tests forever.
// Assumes one chip and a controller that returns burst_len beats per read
// request. Outputs hold while local_ready is low.
module ddr2_traffic_gen
  import mem_if_pkg::*, traffic_pkg::*;
#(
  parameter int max_row   = 3,
  parameter int max_col   = 16,
  parameter int max_bank  = 3,
  parameter int burst_len = 2
) (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        local_ready,
  input  data_t       local_rdata,
  input  logic        local_rdata_valid,
  output logic        local_write_req,
  output logic        local_read_req,
  output logic        local_burstbegin,
  output row_t        local_row_addr,
  output col_t        local_col_addr,
  output bank_t       local_bank_addr,
  output size_t       local_size,
  output be_t         local_be,
  output data_t       local_wdata,
  output be_t         pnf_per_byte,
  output logic        pnf_persist,
  output logic        test_complete,
  output logic [7:0]  test_status
);

  phase_t               phase;
  logic                 phase_restart;
  logic                 write_beat;
  logic                 addr_restart;
  logic                 addr_step;
  logic                 at_last;
  logic                 lane_restart;
  logic                 lane_step;
  logic                 zero_data;
  logic [num_lanes-1:0] lane_ok;
  logic [num_lanes-1:0] lane_ok_valid;

  // every request carries a full burst
  assign local_size = size_t'(burst_len);

  test_sequencer #(
    .burst_len (burst_len)
  ) u_test_sequencer (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .at_last           (at_last),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burstbegin        (local_burstbegin),
    .phase             (phase),
    .phase_restart     (phase_restart),
    .write_beat        (write_beat),
    .addr_restart      (addr_restart),
    .addr_step         (addr_step),
    .test_complete     (test_complete),
    .test_status       (test_status)
  );

  addr_sweep #(
    .max_row   (max_row),
    .max_col   (max_col),
    .max_bank  (max_bank),
    .burst_len (burst_len)
  ) u_addr_sweep (
    .clk          (clk),
    .reset_n      (reset_n),
    .addr_restart (addr_restart),
    .addr_step    (addr_step),
    .row          (local_row_addr),
    .col          (local_col_addr),
    .bank         (local_bank_addr),
    .at_last      (at_last)
  );

  pattern_control u_pattern_control (
    .clk               (clk),
    .reset_n           (reset_n),
    .phase             (phase),
    .phase_restart     (phase_restart),
    .write_beat        (write_beat),
    .local_rdata_valid (local_rdata_valid),
    .lane_restart      (lane_restart),
    .lane_step         (lane_step),
    .zero_data         (zero_data),
    .be                (local_be)
  );

  //----------------------------------------------------------------------
  // one checker per byte lane
  //----------------------------------------------------------------------
  for (genvar i = 0; i < num_lanes; i++)
  begin : g_lane
    byte_lane_checker #(
      .seed (lane_t'(lane_seed_base + i * lane_seed_step))
    ) u_byte_lane_checker (
      .clk           (clk),
      .reset_n       (reset_n),
      .lane_restart  (lane_restart),
      .lane_step     (lane_step),
      .zero_data     (zero_data),
      .be_bit        (local_be[i]),
      .rdata_byte    (local_rdata[i*8 +: 8]),
      .rdata_valid   (local_rdata_valid),
      .wbyte         (local_wdata[i*8 +: 8]),
      .lane_ok       (lane_ok[i]),
      .lane_ok_valid (lane_ok_valid[i])
    );
  end

  pnf_collector u_pnf_collector (
    .clk           (clk),
    .reset_n       (reset_n),
    .lane_ok       (lane_ok),
    .lane_ok_valid (lane_ok_valid),
    .pnf_per_byte  (pnf_per_byte),
    .pnf_persist   (pnf_persist)
  );

endmodule

//--- src/mem_if_pkg.sv
// Local port widths of the DDR2 controller.
// Fixed for a single chip of 13 row, 10 column and 2 bank bits
// on a 32-bit local data path with 4 byte enables.
package mem_if_pkg;

  parameter int row_w  = 13;
  parameter int col_w  = 10;
  parameter int bank_w = 2;
  parameter int data_w = 32;
  parameter int be_w   = 4;
  parameter int size_w = 7;

  typedef logic [row_w-1:0]  row_t;
  typedef logic [col_w-1:0]  col_t;
  typedef logic [bank_w-1:0] bank_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [be_w-1:0]   be_t;

  // burst size field, counts beats
  typedef logic [size_w-1:0] size_t;

endpackage

//--- src/pattern_control.sv
// Pattern step rules and the walking byte enable.
// Lanes step on accepted write beats in pattern write phases and on
// read data beats in read phases. The clear pass writes zeros.
module pattern_control
  import mem_if_pkg::*, traffic_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  phase_t phase,
  input  logic   phase_restart,
  input  logic   write_beat,
  input  logic   local_rdata_valid,
  output logic   lane_restart,
  output logic   lane_step,
  output logic   zero_data,
  output be_t    be
);

  logic be_mode;
  logic write_pat;

  assign zero_data    = (phase == clear_write);
  assign be_mode      = (phase == be_write) || (phase == be_read);
  assign write_pat    = is_write_phase(phase) && !zero_data;
  assign lane_restart = phase_restart;
  assign lane_step    = (write_pat & write_beat) |
                        (is_read_phase(phase) & local_rdata_valid);

  // walking enable, one position per pattern step
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (!be_mode)
      be <= '1;
    else if (phase_restart)
      be <= be_t'(1);
    else if (lane_step)
      be <= {be[be_w-2:0], be[be_w-1]};
  end

endmodule

//--- src/pnf_collector.sv
// Pass/fail collection over all byte lanes.
// pnf_per_byte holds the last result of each lane between beats.
// pnf_persist goes high on a passing first beat and, once low after
// a failure, stays low until reset.
module pnf_collector
  import mem_if_pkg::*, traffic_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [num_lanes-1:0] lane_ok,
  input  logic [num_lanes-1:0] lane_ok_valid,
  output be_t                  pnf_per_byte,
  output logic                 pnf_persist
);

  logic seen_beat;
  logic beat_ok;

  // lanes without a result this cycle count as passing
  assign beat_ok = &(lane_ok | ~lane_ok_valid);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      pnf_per_byte <= '1;
      pnf_persist  <= 1'b0;
      seen_beat    <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < num_lanes; i++)
      begin
        if (lane_ok_valid[i])
          pnf_per_byte[i] <= lane_ok[i];
      end
      if (|lane_ok_valid)
      begin
        seen_beat   <= 1'b1;
        pnf_persist <= seen_beat ? (pnf_persist & beat_ok) : beat_ok;
      end
    end
  end

endmodule

//--- src/test_sequencer.sv
// Phase FSM and request generator.
// Write phases hold write_req for whole bursts of burst_len beats.
// Read phases issue requests back to back and close only when every
// requested beat has come back, so burst_len must match the controller.
// The outstanding count is 8 bits wide.
module test_sequencer
  import mem_if_pkg::*, traffic_pkg::*;
#(
  parameter int burst_len = 2
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       local_ready,
  input  logic       local_rdata_valid,
  input  logic       at_last,
  output logic       write_req,
  output logic       read_req,
  output logic       burstbegin,
  output phase_t     phase,
  output logic       phase_restart,
  output logic       write_beat,
  output logic       addr_restart,
  output logic       addr_step,
  output logic       test_complete,
  output logic [7:0] test_status
);

  size_t      beat_cnt;
  logic       rd_issued;
  logic [7:0] outstanding;
  logic [7:0] out_next;
  logic       wr_acc;
  logic       rd_acc;
  logic       last_beat;

  function automatic phase_t next_phase(phase_t p);
    case (p)
      seq_write:   return seq_read;
      seq_read:    return clear_write;
      clear_write: return be_write;
      be_write:    return be_read;
      be_read:     return drain;
      default:     return seq_write;
    endcase
  endfunction

  assign wr_acc    = write_req & local_ready;
  assign rd_acc    = read_req & local_ready;
  assign last_beat = (beat_cnt == size_t'(burst_len - 1));

  assign write_beat   = wr_acc;
  // one address step per burst, after its last write beat
  assign addr_step    = (wr_acc & last_beat) | rd_acc;
  assign addr_restart = phase_restart;
  assign burstbegin   = (write_req & (beat_cnt == '0)) | read_req;

  always_comb
  begin
    test_status    = '0;
    test_status[0] = (phase == seq_write) || (phase == seq_read);
    test_status[2] = (phase == clear_write) || (phase == be_write) || (phase == be_read);
    test_status[7] = test_complete;
  end

  // beats still owed by the controller
  always_comb
  begin
    out_next = outstanding;
    if (rd_acc)
      out_next = out_next + 8'(burst_len);
    if (local_rdata_valid && (out_next != '0))
      out_next = out_next - 8'd1;
  end

  //----------------------------------------------------------------------
  // phase FSM
  //----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      phase         <= idle;
      phase_restart <= 1'b0;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      beat_cnt      <= '0;
      rd_issued     <= 1'b0;
      outstanding   <= '0;
      test_complete <= 1'b0;
    end
    else
    begin
      outstanding   <= out_next;
      phase_restart <= 1'b0;
      if (phase_restart)
      begin
        // new phase begins, raise its request
        beat_cnt  <= '0;
        rd_issued <= 1'b0;
        write_req <= is_write_phase(phase);
        read_req  <= is_read_phase(phase);
      end
      else
      begin
        case (phase)
          idle:
          begin
            phase         <= seq_write;
            phase_restart <= 1'b1;
          end
          seq_write, clear_write, be_write:
          begin
            if (wr_acc)
            begin
              if (last_beat)
              begin
                beat_cnt <= '0;
                if (at_last)
                begin
                  write_req     <= 1'b0;
                  phase         <= next_phase(phase);
                  phase_restart <= 1'b1;
                end
              end
              else
                beat_cnt <= beat_cnt + size_t'(1);
            end
          end
          seq_read, be_read:
          begin
            if (rd_acc && at_last)
            begin
              read_req  <= 1'b0;
              rd_issued <= 1'b1;
            end
            else if (rd_issued && (outstanding == '0))
            begin
              phase         <= next_phase(phase);
              phase_restart <= 1'b1;
            end
          end
          drain:
          begin
            if (outstanding == '0)
            begin
              test_complete <= 1'b1;
              phase         <= seq_write;
              phase_restart <= 1'b1;
            end
          end
          default:
            phase <= idle;
        endcase
      end
    end
  end

endmodule

//--- src/traffic_pkg.sv
// Test phases and data pattern constants for the traffic generator.
// Lane count must equal the number of byte enables on the local port.
// The LFSR is 8 bits wide and never reaches the all-zero state
// from a nonzero seed.
package traffic_pkg;

  parameter int num_lanes = 4;

  typedef logic [7:0] lane_t;

  // lane i seed = base + i * step
  parameter int lane_seed_base = 1;
  parameter int lane_seed_step = 10;

  // taps 8, 6, 5, 4 of a left-shifting LFSR
  parameter lane_t lfsr_taps = 8'b1011_1000;

  typedef enum logic [2:0] {
    idle,
    seq_write,
    seq_read,
    clear_write,
    be_write,
    be_read,
    drain
  } phase_t;

  function automatic logic is_write_phase(phase_t p);
    return (p == seq_write) || (p == clear_write) || (p == be_write);
  endfunction

  function automatic logic is_read_phase(phase_t p);
    return (p == seq_read) || (p == be_read);
  endfunction

endpackage

//--- tb/tb_ddr2_traffic_gen.sv
// Testbench for the DDR2 traffic generator.
// A byte-wide memory model stands in for the controller, with random
// ready and a read latency of 2 to 5 cycles. After the first full test
// one byte of a later read beat is corrupted.
module tb_ddr2_traffic_gen
  import mem_if_pkg::*;
;

  localparam int burst_len = 2;

  logic        clk;
  logic        reset_n;
  logic        local_ready;
  data_t       local_rdata;
  logic        local_rdata_valid;
  logic        local_write_req;
  logic        local_read_req;
  logic        local_burstbegin;
  row_t        local_row_addr;
  col_t        local_col_addr;
  bank_t       local_bank_addr;
  size_t       local_size;
  be_t         local_be;
  data_t       local_wdata;
  be_t         pnf_per_byte;
  logic        pnf_persist;
  logic        test_complete;
  logic [7:0]  test_status;

  logic        fault_hit;
  logic        fault_armed;
  logic [1:0]  fault_lane;
  int          fault_at;
  int          rbeats;
  int          cycle;
  int          wbeat;
  int          errors;
  int          n;
  int          lat;
  int          rnd;
  logic        ok;
  logic [15:0] lfsr_state;
  logic [7:0]  mem [int];
  int          pend_key[$];
  int          pend_due[$];

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  function automatic int mem_key(int bank, int row, int col, int lane);
    return (((bank * 8192 + row) * 1024 + col) * 4) + lane;
  endfunction

  initial
  begin
    clk = 0;
    forever #20 clk = ~clk;
  end

  //----------------------------------------------------------------------
  // controller and memory model
  //----------------------------------------------------------------------
  initial
  begin
    local_ready = 0;
    local_rdata = '0;
    local_rdata_valid = 0;
    fault_hit = 0;
    lfsr_state = 16'd43;
    cycle = 0;
    wbeat = 0;
    rbeats = 0;
    forever
    begin
      @(posedge clk);
      cycle++;
      if (reset_n && local_write_req && local_ready)
      begin
        for (int l = 0; l < 4; l++)
          if (local_be[l])
            mem[mem_key(local_bank_addr, local_row_addr, int'(local_col_addr) + wbeat, l)]
              = local_wdata[l*8 +: 8];
        wbeat = (wbeat + 1) % burst_len;
      end
      if (reset_n && local_read_req && local_ready)
      begin
        take_bits(2, lat);
        for (int b = 0; b < burst_len; b++)
        begin
          pend_key.push_back(mem_key(local_bank_addr, local_row_addr,
                                     int'(local_col_addr) + b, 0));
          pend_due.push_back(cycle + 2 + lat);
        end
      end
      #2;
      take_bits(2, rnd);
      local_ready = (rnd != 0);
      local_rdata_valid = 0;
      fault_hit = 0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle)
      begin
        for (int l = 0; l < 4; l++)
          local_rdata[l*8 +: 8] = mem.exists(pend_key[0] + l) ? mem[pend_key[0] + l] : 8'h00;
        if (fault_armed && rbeats == fault_at)
        begin
          local_rdata[fault_lane*8 +: 8] = local_rdata[fault_lane*8 +: 8] ^ 8'hff;
          fault_hit = 1;
        end
        local_rdata_valid = 1;
        rbeats++;
        void'(pend_key.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

  ddr2_traffic_gen #(
    .burst_len (burst_len)
  ) u_ddr2_traffic_gen (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .local_row_addr    (local_row_addr),
    .local_col_addr    (local_col_addr),
    .local_bank_addr   (local_bank_addr),
    .local_size        (local_size),
    .local_be          (local_be),
    .local_wdata       (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete),
    .test_status       (test_status)
  );

  traffic_checker #(
    .burst_len (burst_len)
  ) u_traffic_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burstbegin        (local_burstbegin),
    .row_addr          (local_row_addr),
    .col_addr          (local_col_addr),
    .bank_addr         (local_bank_addr),
    .size              (local_size),
    .be                (local_be),
    .wdata             (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete),
    .test_status       (test_status),
    .fault_hit         (fault_hit),
    .fault_lane        (fault_lane),
    .error_count       (errors)
  );

  //----------------------------------------------------------------------
  // test sequence
  //----------------------------------------------------------------------
  initial
  begin
    reset_n = 0;
    fault_armed = 0;
    fault_lane = 2'd2;
    fault_at = 0;
    ok = 1;
    repeat (4) @(posedge clk);
    #2 reset_n = 1;

    n = 0;
    while (!test_complete && n < 20000)
    begin
      @(posedge clk);
      n++;
    end
    if (!test_complete)
    begin
      $display("timeout waiting for test_complete");
      ok = 0;
    end
    if (ok)
    begin
      fault_at = rbeats + 25;
      fault_armed = 1;
      n = 0;
      while (!fault_hit && n < 5000)
      begin
        @(posedge clk);
        n++;
      end
      if (!fault_hit)
      begin
        $display("timeout waiting for the corrupted read beat");
        ok = 0;
      end
    end
    if (ok)
    begin
      n = 0;
      while (pnf_persist && n < 20)
      begin
        @(posedge clk);
        n++;
      end
      if (pnf_persist)
      begin
        $display("pnf_persist never fell after the corrupted beat");
        ok = 0;
      end
    end
    if (ok)
      repeat (300) @(posedge clk);

    $display("checker errors: %0d, run completed: %0d", errors, ok);
    if (!ok || errors != 0)
      $display("Done: errors found");
    else
      $display("Done: no errors");
    $finish;
  end

endmodule

//--- tb/traffic_checker.sv
// Watches the traffic generator ports and compares them with a reference.
// Tracks write and read passes by counting accepted bursts, so it must
// see the run from reset. Read data itself is judged through pnf flags.
module traffic_checker
  import mem_if_pkg::*;
#(
  parameter int max_row   = 3,
  parameter int max_col   = 16,
  parameter int max_bank  = 3,
  parameter int burst_len = 2
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       local_ready,
  input  logic       local_rdata_valid,
  input  logic       write_req,
  input  logic       read_req,
  input  logic       burstbegin,
  input  row_t       row_addr,
  input  col_t       col_addr,
  input  bank_t      bank_addr,
  input  size_t      size,
  input  be_t        be,
  input  data_t      wdata,
  input  be_t        pnf_per_byte,
  input  logic       pnf_persist,
  input  logic       test_complete,
  input  logic [7:0] test_status,
  input  logic       fault_hit,
  input  logic [1:0] fault_lane,
  output int         error_count
);

  localparam int col_step = 2 * burst_len;
  localparam int n_cols   = (max_col + col_step - 1) / col_step + 1;
  localparam int n_bursts = n_cols * (max_row + 1) * (max_bank + 1);

  logic [7:0]  pat [4];
  logic [3:0]  exp_be;
  int          wr_pass;
  int          wr_beats;
  int          burst_beat;
  int          ec;
  int          er;
  int          eb;
  int          rd_pass;
  int          rd_reqs;
  int          rd_done;
  int          rc;
  int          rr;
  int          rb;
  logic        fault_seen;
  logic        first_rd;
  logic        done_seen;
  int          fault_age;
  int          rd_age;
  logic        prev_valid;
  logic        prev_wr;
  logic        prev_rd;
  logic        prev_bb;
  logic        prev_ready;
  logic [31:0] prev_addr;
  logic [31:0] prev_wdata;
  logic [3:0]  prev_be;

  // 8-bit pattern, taps 8 6 5 4, shift left
  function automatic logic [7:0] pattern_step(logic [7:0] p);
    return {p[6:0], p[7] ^ p[5] ^ p[4] ^ p[3]};
  endfunction

  // column, then row, then bank carry
  function automatic void sweep_next(inout int c, inout int r, inout int b);
    if (c < max_col)
      c = c + col_step;
    else
    begin
      c = 0;
      if (r < max_row)
        r = r + 1;
      else
      begin
        r = 0;
        b = (b < max_bank) ? b + 1 : 0;
      end
    end
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  initial
  begin
    error_count = 0;
    wr_pass = 0;
    wr_beats = 0;
    burst_beat = 0;
    rd_pass = 0;
    rd_reqs = 0;
    rd_done = 0;
    fault_seen = 0;
    fault_age = 0;
    first_rd = 0;
    done_seen = 0;
    rd_age = 0;
    prev_valid = 0;
  end

  always @(posedge clk)
  begin
    if (reset_n)
    begin
      // status bits that never change meaning
      check_val("test_status[7]", 32'(test_status[7]), 32'(test_complete));
      check_val("test_status unused", 32'({test_status[6:3], test_status[1]}), 0);
      check_val("local_size", 32'(size), burst_len);

      // completion only after both read passes, then sticky
      if (done_seen)
        check_val("test_complete", 32'(test_complete), 1);
      else if (test_complete)
      begin
        done_seen = 1;
        if (rd_done < 2)
        begin
          error_count++;
          $display("test_complete rose before both read passes ended at %0t", $time);
        end
      end

      // outputs frozen under back-pressure
      if (prev_valid && (prev_wr || prev_rd) && !prev_ready)
      begin
        check_val("write_req hold", 32'(write_req), 32'(prev_wr));
        check_val("read_req hold", 32'(read_req), 32'(prev_rd));
        check_val("burstbegin hold", 32'(burstbegin), 32'(prev_bb));
        check_val("address hold", 32'({bank_addr, row_addr, col_addr}), prev_addr);
        if (prev_wr)
        begin
          check_val("local_wdata hold", wdata, prev_wdata);
          check_val("local_be hold", 32'(be), 32'(prev_be));
        end
      end

      //--------------------------------------------------------------------
      // accepted write beat
      //--------------------------------------------------------------------
      if (write_req && local_ready)
      begin
        if (wr_beats == 0)
        begin
          for (int i = 0; i < 4; i++)
            pat[i] = 8'(1 + 10 * i);
          exp_be = (wr_pass == 2) ? 4'b0001 : 4'b1111;
          ec = 0;
          er = 0;
          eb = 0;
          burst_beat = 0;
        end
        if (wr_pass == 1)
          check_val("local_wdata", wdata, 0);
        else
          check_val("local_wdata", wdata, {pat[3], pat[2], pat[1], pat[0]});
        check_val("local_be", 32'(be), 32'(exp_be));
        // address holds the burst start for every beat
        check_val("local_col_addr", 32'(col_addr), ec);
        check_val("local_row_addr", 32'(row_addr), er);
        check_val("local_bank_addr", 32'(bank_addr), eb);
        check_val("local_burstbegin", 32'(burstbegin), 32'(burst_beat == 0));
        check_val("test_status[2,0]", 32'({test_status[2], test_status[0]}),
                  (wr_pass == 0) ? 1 : 2);
        if (wr_pass != 1)
          for (int i = 0; i < 4; i++)
            pat[i] = pattern_step(pat[i]);
        if (wr_pass == 2)
          exp_be = {exp_be[2:0], exp_be[3]};
        burst_beat++;
        if (burst_beat == burst_len)
        begin
          burst_beat = 0;
          sweep_next(ec, er, eb);
        end
        wr_beats++;
        if (wr_beats == n_bursts * burst_len)
        begin
          wr_beats = 0;
          wr_pass = (wr_pass + 1) % 3;
        end
      end

      // accepted read request
      if (read_req && local_ready)
      begin
        if (rd_reqs == 0)
        begin
          rc = 0;
          rr = 0;
          rb = 0;
        end
        check_val("read local_col_addr", 32'(col_addr), rc);
        check_val("read local_row_addr", 32'(row_addr), rr);
        check_val("read local_bank_addr", 32'(bank_addr), rb);
        check_val("read local_burstbegin", 32'(burstbegin), 1);
        check_val("test_status[2,0]", 32'({test_status[2], test_status[0]}),
                  (rd_pass == 0) ? 1 : 2);
        sweep_next(rc, rr, rb);
        rd_reqs++;
        if (rd_reqs == n_bursts)
        begin
          rd_reqs = 0;
          rd_pass = 1 - rd_pass;
          rd_done++;
        end
      end

      //--------------------------------------------------------------------
      // pass/fail flags
      //--------------------------------------------------------------------
      if (!fault_seen)
      begin
        if (rd_age >= 2)
        begin
          check_val("pnf_persist", 32'(pnf_persist), 1);
          check_val("pnf_per_byte", 32'(pnf_per_byte), 32'hf);
        end
        else
        begin
          // nothing judged yet
          check_val("pnf_persist", 32'(pnf_persist), 0);
          check_val("pnf_per_byte", 32'(pnf_per_byte), 32'hf);
        end
      end
      else
      begin
        if (fault_age == 2)
          check_val("pnf_per_byte faulty lane", 32'(pnf_per_byte[fault_lane]), 0);
        if (fault_age >= 2)
          check_val("pnf_persist after fault", 32'(pnf_persist), 0);
        if (fault_age < 10)
          fault_age++;
      end
      if (local_rdata_valid && fault_hit && !fault_seen)
      begin
        fault_seen = 1;
        fault_age = 1;
      end
      if (local_rdata_valid)
        first_rd = 1;
      if (first_rd && rd_age < 10)
        rd_age++;

      prev_valid = 1;
      prev_wr = write_req;
      prev_rd = read_req;
      prev_bb = burstbegin;
      prev_ready = local_ready;
      prev_addr = 32'({bank_addr, row_addr, col_addr});
      prev_wdata = wdata;
      prev_be = be;
    end
  end

endmodule
